/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= rv64_core.f
TB_TOP    ?= tb_rv64_core
RTL_TOP   ?= rv64_core
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

$(OBJ_DIR)/V$(TB_TOP): $(FILELIST) hdl/*.sv hdl/*.svh sim/*.sv
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TB_TOP)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* hdl/rv64_core.sv */
`timescale 1ns/1ps
`include "rv64_defines.svh"

module rv64_core (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  rv64_pkg::inst_t   inst_i,
  output rv64_pkg::xlen_t   pc_o,
  output rv64_pkg::commit_t commit_o,
  output logic              halted_o,
  output logic              invalid_o
);

  rv64_pkg::xlen_t       pc;
  rv64_pkg::reg_idx_t    rs1_idx, rs2_idx;
  logic                  rs1_en, rs2_en;
  rv64_pkg::xlen_t       rs1_data, rs2_data;
  rv64_pkg::idu_to_exu_t dec;
  rv64_pkg::commit_t     commit;
  logic                  redirect;
  rv64_pkg::xlen_t       redirect_pc;
  logic                  ebreak, invalid;
  logic                  stop;

  // ebreak and bad opcodes both halt fetch
  assign stop = ebreak | invalid;

  rv64_ifu u_ifu (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc),
    .stop_i        (stop),
    .pc_o          (pc),
    .halted_o      (halted_o)
  );

  rv64_idu u_idu (
    .inst_i        (inst_i),
    .pc_i          (pc),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .rs1_idx_o     (rs1_idx),
    .rs2_idx_o     (rs2_idx),
    .rs1_read_en_o (rs1_en),
    .rs2_read_en_o (rs2_en),
    .dec_o         (dec),
    .ebreak_o      (ebreak),
    .invalid_o     (invalid)
  );

  rv64_regfile u_regfile (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .rs1_idx_i  (rs1_idx),
    .rs2_idx_i  (rs2_idx),
    .rs1_en_i   (rs1_en),
    .rs2_en_i   (rs2_en),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .wb_i       (commit)
  );

  rv64_exu u_exu (
    .dec_i         (dec),
    .commit_o      (commit),
    .redirect_o    (redirect),
    .redirect_pc_o (redirect_pc)
  );

  assign pc_o      = pc;
  assign commit_o  = commit;
  assign invalid_o = invalid;

endmodule

/* hdl/rv64_defines.svh */
`ifndef RV64_DEFINES_SVH
`define RV64_DEFINES_SVH

// Datapath widths
`define RV64_XLEN        64
`define RV64_INST_W      32
`define RV64_REG_IDX_W   5

// Execute info bus, unit tag in the low bits
`define RV64_EXU_INFO_W  15
`define RV64_EXU_TAG_W   3

// First fetch address out of reset
`define RV64_RESET_PC    64'h8000_0000

// Unit tags
`define RV64_EXU_TAG_ALU 3'b000
`define RV64_EXU_TAG_BJP 3'b001

// ALU operation lines
`define RV64_EXU_INFO_ALU_ADD    3
`define RV64_EXU_INFO_ALU_SUB    4
`define RV64_EXU_INFO_ALU_SLL    5
`define RV64_EXU_INFO_ALU_SLT    6
`define RV64_EXU_INFO_ALU_SLTU   7
`define RV64_EXU_INFO_ALU_XOR    8
`define RV64_EXU_INFO_ALU_SRL    9
`define RV64_EXU_INFO_ALU_SRA    10
`define RV64_EXU_INFO_ALU_OR     11
`define RV64_EXU_INFO_ALU_AND    12
`define RV64_EXU_INFO_ALU_LUI    13
`define RV64_EXU_INFO_ALU_EBREAK 14

// Branch and jump operation lines
`define RV64_EXU_INFO_BJP_JAL    3
`define RV64_EXU_INFO_BJP_JALR   4
`define RV64_EXU_INFO_BJP_BEQ    5
`define RV64_EXU_INFO_BJP_BNE    6
`define RV64_EXU_INFO_BJP_BLT    7
`define RV64_EXU_INFO_BJP_BGE    8
`define RV64_EXU_INFO_BJP_BLTU   9
`define RV64_EXU_INFO_BJP_BGEU   10

`endif

/* hdl/rv64_exu.sv */
`timescale 1ns/1ps
`include "rv64_defines.svh"

module rv64_exu (
  input  rv64_pkg::idu_to_exu_t dec_i,
  output rv64_pkg::commit_t     commit_o,
  output logic                  redirect_o,
  output rv64_pkg::xlen_t       redirect_pc_o
);

  rv64_pkg::exu_info_t info;
  rv64_pkg::xlen_t     op1, op2;
  logic                is_alu, is_bjp;

  assign info   = dec_i.exu_info;
  assign op1    = dec_i.op1;
  assign op2    = dec_i.op2;
  assign is_alu = (info[`RV64_EXU_TAG_W-1:0] == `RV64_EXU_TAG_ALU);
  assign is_bjp = (info[`RV64_EXU_TAG_W-1:0] == `RV64_EXU_TAG_BJP);

  // Jumps and branches
  logic j_jal, j_jalr, b_beq, b_bne, b_blt, b_bge, b_bltu, b_bgeu;
  assign j_jal  = is_bjp & info[`RV64_EXU_INFO_BJP_JAL];
  assign j_jalr = is_bjp & info[`RV64_EXU_INFO_BJP_JALR];
  assign b_beq  = is_bjp & info[`RV64_EXU_INFO_BJP_BEQ];
  assign b_bne  = is_bjp & info[`RV64_EXU_INFO_BJP_BNE];
  assign b_blt  = is_bjp & info[`RV64_EXU_INFO_BJP_BLT];
  assign b_bge  = is_bjp & info[`RV64_EXU_INFO_BJP_BGE];
  assign b_bltu = is_bjp & info[`RV64_EXU_INFO_BJP_BLTU];
  assign b_bgeu = is_bjp & info[`RV64_EXU_INFO_BJP_BGEU];

  // ALU lines, jal and jalr add pc + 4 for the link
  logic a_add, a_sub, a_sll, a_slt, a_sltu, a_xor, a_srl, a_sra, a_or, a_and, a_lui;
  assign a_add  = (is_alu & info[`RV64_EXU_INFO_ALU_ADD]) | j_jal | j_jalr;
  assign a_sub  = is_alu & info[`RV64_EXU_INFO_ALU_SUB];
  assign a_sll  = is_alu & info[`RV64_EXU_INFO_ALU_SLL];
  assign a_slt  = is_alu & info[`RV64_EXU_INFO_ALU_SLT];
  assign a_sltu = is_alu & info[`RV64_EXU_INFO_ALU_SLTU];
  assign a_xor  = is_alu & info[`RV64_EXU_INFO_ALU_XOR];
  assign a_srl  = is_alu & info[`RV64_EXU_INFO_ALU_SRL];
  assign a_sra  = is_alu & info[`RV64_EXU_INFO_ALU_SRA];
  assign a_or   = is_alu & info[`RV64_EXU_INFO_ALU_OR];
  assign a_and  = is_alu & info[`RV64_EXU_INFO_ALU_AND];
  assign a_lui  = is_alu & info[`RV64_EXU_INFO_ALU_LUI];

  // Comparisons shared by slt/sltu and the branch unit
  logic op_eq, op_lt, op_ltu;
  assign op_eq  = (op1 == op2);
  assign op_lt  = ($signed(op1) < $signed(op2));
  assign op_ltu = (op1 < op2);

  // Shift amount is the low 6 bits
  logic [5:0] shamt;
  assign shamt = op2[5:0];

  rv64_pkg::xlen_t sum, diff, sll_res, srl_res, sra_res, alu_res;
  assign sum     = op1 + op2;
  assign diff    = op1 - op2;
  assign sll_res = op1 << shamt;
  assign srl_res = op1 >> shamt;
  assign sra_res = $signed(op1) >>> shamt;

  assign alu_res = ({`RV64_XLEN{a_add}} & sum)
                 | ({`RV64_XLEN{a_sub}} & diff)
                 | ({`RV64_XLEN{a_sll}} & sll_res)
                 | ({`RV64_XLEN{a_slt}} & rv64_pkg::xlen_t'(op_lt))
                 | ({`RV64_XLEN{a_sltu}} & rv64_pkg::xlen_t'(op_ltu))
                 | ({`RV64_XLEN{a_xor}} & (op1 ^ op2))
                 | ({`RV64_XLEN{a_srl}} & srl_res)
                 | ({`RV64_XLEN{a_sra}} & sra_res)
                 | ({`RV64_XLEN{a_or}} & (op1 | op2))
                 | ({`RV64_XLEN{a_and}} & (op1 & op2))
                 | ({`RV64_XLEN{a_lui}} & op2);

  // Taken when a jump or a branch condition holds
  assign redirect_o = j_jal | j_jalr
                    | (b_beq & op_eq) | (b_bne & ~op_eq)
                    | (b_blt & op_lt) | (b_bge & ~op_lt)
                    | (b_bltu & op_ltu) | (b_bgeu & ~op_ltu);

  rv64_pkg::xlen_t target;
  assign target = dec_i.op1_jp + dec_i.op2_jp;
  // jalr drops bit 0
  assign redirect_pc_o = {target[`RV64_XLEN-1:1], target[0] & ~j_jalr};

  assign commit_o.en   = dec_i.rd_wr_en;
  assign commit_o.idx  = dec_i.rd_idx;
  assign commit_o.data = alu_res;

  // Decode sets at most one operation line per instruction
  always_comb begin
    assert ($isunknown(info) || $onehot0(info[`RV64_EXU_INFO_W-1:`RV64_EXU_TAG_W]))
      else $error("exu: operation bus not one-hot");
  end

endmodule

/* hdl/rv64_idu.sv */
`timescale 1ns/1ps
`include "rv64_defines.svh"

module rv64_idu (
  input  rv64_pkg::inst_t       inst_i,
  input  rv64_pkg::xlen_t       pc_i,
  input  rv64_pkg::xlen_t       rs1_data_i,
  input  rv64_pkg::xlen_t       rs2_data_i,
  output rv64_pkg::reg_idx_t    rs1_idx_o,
  output rv64_pkg::reg_idx_t    rs2_idx_o,
  output logic                  rs1_read_en_o,
  output logic                  rs2_read_en_o,
  output rv64_pkg::idu_to_exu_t dec_o,
  output logic                  ebreak_o,
  output logic                  invalid_o
);

  logic [6:0]         opcode;
  logic [2:0]         funct3;
  logic [6:0]         funct7;
  logic [5:0]         funct6;
  rv64_pkg::reg_idx_t rd;
  rv64_pkg::reg_idx_t rs1;

  assign opcode = inst_i[6:0];
  assign rd     = inst_i[11:7];
  assign funct3 = inst_i[14:12];
  assign rs1    = inst_i[19:15];
  assign funct7 = inst_i[31:25];
  // RV64 shifts carry a 6-bit shamt, so only the top six bits select
  assign funct6 = inst_i[31:26];

  assign rs1_idx_o = rs1;
  assign rs2_idx_o = inst_i[24:20];

  // Opcode classes, loads and stores fall through as invalid
  logic op_r, op_i, op_b, op_jal, op_jalr, op_lui, op_auipc, op_sys;
  assign op_r     = (opcode == 7'b0110011);
  assign op_i     = (opcode == 7'b0010011);
  assign op_b     = (opcode == 7'b1100011);
  assign op_jal   = (opcode == 7'b1101111);
  assign op_jalr  = (opcode == 7'b1100111);
  assign op_lui   = (opcode == 7'b0110111);
  assign op_auipc = (opcode == 7'b0010111);
  assign op_sys   = (opcode == 7'b1110011);

  // Immediates
  rv64_pkg::xlen_t imm_i, imm_b, imm_u, imm_j, imm;
  assign imm_i = {{52{inst_i[31]}}, inst_i[31:20]};
  assign imm_b = {{52{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
  // U already sits in bits 31..12
  assign imm_u = {{32{inst_i[31]}}, inst_i[31:12], 12'b0};
  assign imm_j = {{44{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

  // Funct field matches
  logic f7_00, f7_20, f6_00, f6_10;
  assign f7_00 = (funct7 == 7'b000_0000);
  assign f7_20 = (funct7 == 7'b010_0000);
  assign f6_00 = (funct6 == 6'b00_0000);
  assign f6_10 = (funct6 == 6'b01_0000);

  // R-type lines
  logic i_add, i_sub, i_sll, i_slt, i_sltu, i_xor, i_srl, i_sra, i_or, i_and;
  assign i_add  = op_r & (funct3 == 3'd0) & f7_00;
  assign i_sub  = op_r & (funct3 == 3'd0) & f7_20;
  assign i_sll  = op_r & (funct3 == 3'd1) & f7_00;
  assign i_slt  = op_r & (funct3 == 3'd2) & f7_00;
  assign i_sltu = op_r & (funct3 == 3'd3) & f7_00;
  assign i_xor  = op_r & (funct3 == 3'd4) & f7_00;
  assign i_srl  = op_r & (funct3 == 3'd5) & f7_00;
  assign i_sra  = op_r & (funct3 == 3'd5) & f7_20;
  assign i_or   = op_r & (funct3 == 3'd6) & f7_00;
  assign i_and  = op_r & (funct3 == 3'd7) & f7_00;

  // I-type lines
  logic i_addi, i_slli, i_slti, i_sltiu, i_xori, i_srli, i_srai, i_ori, i_andi;
  assign i_addi  = op_i & (funct3 == 3'd0);
  assign i_slli  = op_i & (funct3 == 3'd1) & f6_00;
  assign i_slti  = op_i & (funct3 == 3'd2);
  assign i_sltiu = op_i & (funct3 == 3'd3);
  assign i_xori  = op_i & (funct3 == 3'd4);
  assign i_srli  = op_i & (funct3 == 3'd5) & f6_00;
  assign i_srai  = op_i & (funct3 == 3'd5) & f6_10;
  assign i_ori   = op_i & (funct3 == 3'd6);
  assign i_andi  = op_i & (funct3 == 3'd7);

  // Branches, jumps, upper immediates, ebreak
  logic i_beq, i_bne, i_blt, i_bge, i_bltu, i_bgeu;
  logic i_jal, i_jalr, i_lui, i_auipc, i_ebreak;
  assign i_beq    = op_b & (funct3 == 3'd0);
  assign i_bne    = op_b & (funct3 == 3'd1);
  assign i_blt    = op_b & (funct3 == 3'd4);
  assign i_bge    = op_b & (funct3 == 3'd5);
  assign i_bltu   = op_b & (funct3 == 3'd6);
  assign i_bgeu   = op_b & (funct3 == 3'd7);
  assign i_jal    = op_jal;
  assign i_jalr   = op_jalr & (funct3 == 3'd0);
  assign i_lui    = op_lui;
  assign i_auipc  = op_auipc;
  assign i_ebreak = op_sys & (funct3 == 3'd0) & (rd == '0) & (rs1 == '0)
                  & (inst_i[31:20] == 12'h001);

  // Unit grouping
  logic alu_calc, alu_op, bjp_op, branch;
  assign alu_calc = i_add | i_sub | i_sll | i_slt | i_sltu | i_xor | i_srl | i_sra
                  | i_or | i_and | i_addi | i_slli | i_slti | i_sltiu | i_xori
                  | i_srli | i_srai | i_ori | i_andi | i_lui | i_auipc;
  assign alu_op   = alu_calc | i_ebreak;
  assign branch   = i_beq | i_bne | i_blt | i_bge | i_bltu | i_bgeu;
  assign bjp_op   = branch | i_jal | i_jalr;

  assign ebreak_o  = i_ebreak;
  // Anything not matched above, funct mismatches included
  assign invalid_o = ~(alu_op | bjp_op);

  assign imm = ({`RV64_XLEN{op_i | i_jalr}} & imm_i)
             | ({`RV64_XLEN{op_b}} & imm_b)
             | ({`RV64_XLEN{i_jal}} & imm_j)
             | ({`RV64_XLEN{i_lui | i_auipc}} & imm_u);

  // Register read needs
  assign rs1_read_en_o = op_r | op_i | op_b | i_jalr;
  assign rs2_read_en_o = op_r | op_b;

  // Operand sources, lui leaves op1 at zero
  logic op1_rs1, op1_pc, op2_rs2, op2_imm, op2_four, jp_pc;
  assign op1_rs1  = op_r | op_i | op_b;
  assign op1_pc   = i_auipc | i_jal | i_jalr;
  assign op2_rs2  = op_r | op_b;
  assign op2_imm  = op_i | i_auipc | i_lui;
  // Link value is pc + 4
  assign op2_four = i_jal | i_jalr;
  assign jp_pc    = op_b | i_jal;

  // Operation lines per unit
  rv64_pkg::exu_info_t alu_info, bjp_info;
  always_comb begin
    alu_info = '0;
    alu_info[`RV64_EXU_TAG_W-1:0]         = `RV64_EXU_TAG_ALU;
    alu_info[`RV64_EXU_INFO_ALU_ADD]    = i_add | i_addi | i_auipc;
    alu_info[`RV64_EXU_INFO_ALU_SUB]    = i_sub;
    alu_info[`RV64_EXU_INFO_ALU_SLL]    = i_sll | i_slli;
    alu_info[`RV64_EXU_INFO_ALU_SLT]    = i_slt | i_slti;
    alu_info[`RV64_EXU_INFO_ALU_SLTU]   = i_sltu | i_sltiu;
    alu_info[`RV64_EXU_INFO_ALU_XOR]    = i_xor | i_xori;
    alu_info[`RV64_EXU_INFO_ALU_SRL]    = i_srl | i_srli;
    alu_info[`RV64_EXU_INFO_ALU_SRA]    = i_sra | i_srai;
    alu_info[`RV64_EXU_INFO_ALU_OR]     = i_or | i_ori;
    alu_info[`RV64_EXU_INFO_ALU_AND]    = i_and | i_andi;
    alu_info[`RV64_EXU_INFO_ALU_LUI]    = i_lui;
    alu_info[`RV64_EXU_INFO_ALU_EBREAK] = i_ebreak;
  end

  always_comb begin
    bjp_info = '0;
    bjp_info[`RV64_EXU_TAG_W-1:0]     = `RV64_EXU_TAG_BJP;
    bjp_info[`RV64_EXU_INFO_BJP_JAL]  = i_jal;
    bjp_info[`RV64_EXU_INFO_BJP_JALR] = i_jalr;
    bjp_info[`RV64_EXU_INFO_BJP_BEQ]  = i_beq;
    bjp_info[`RV64_EXU_INFO_BJP_BNE]  = i_bne;
    bjp_info[`RV64_EXU_INFO_BJP_BLT]  = i_blt;
    bjp_info[`RV64_EXU_INFO_BJP_BGE]  = i_bge;
    bjp_info[`RV64_EXU_INFO_BJP_BLTU] = i_bltu;
    bjp_info[`RV64_EXU_INFO_BJP_BGEU] = i_bgeu;
  end

  // No write for x0, branches, ebreak or invalid
  assign dec_o.rd_wr_en = (alu_calc | i_jal | i_jalr) & (rd != '0);
  assign dec_o.rd_idx   = rd;
  assign dec_o.op1      = ({`RV64_XLEN{op1_rs1}} & rs1_data_i)
                        | ({`RV64_XLEN{op1_pc}} & pc_i);
  assign dec_o.op2      = ({`RV64_XLEN{op2_rs2}} & rs2_data_i)
                        | ({`RV64_XLEN{op2_imm}} & imm)
                        | ({`RV64_XLEN{op2_four}} & rv64_pkg::xlen_t'(4));
  assign dec_o.op1_jp   = ({`RV64_XLEN{i_jalr}} & rs1_data_i)
                        | ({`RV64_XLEN{jp_pc}} & pc_i);
  assign dec_o.op2_jp   = {`RV64_XLEN{bjp_op}} & imm;
  assign dec_o.exu_info = ({`RV64_EXU_INFO_W{alu_op}} & alu_info)
                        | ({`RV64_EXU_INFO_W{bjp_op}} & bjp_info);

endmodule

/* hdl/rv64_ifu.sv */
`timescale 1ns/1ps
`include "rv64_defines.svh"

module rv64_ifu (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            redirect_i,
  input  rv64_pkg::xlen_t redirect_pc_i,
  input  logic            stop_i,
  output rv64_pkg::xlen_t pc_o,
  output logic            halted_o
);

  rv64_pkg::xlen_t      pc_q;
  rv64_pkg::xlen_t      pc_d;
  rv64_pkg::ifu_state_t state_q;
  rv64_pkg::ifu_state_t state_d;

  // Next pc and next state
  always_comb begin
    pc_d    = pc_q;
    state_d = state_q;
    case (state_q)
      rv64_pkg::IFU_RUN: begin
        // Stop freezes the pc on the ebreak or bad instruction
        if (stop_i) begin
          state_d = rv64_pkg::IFU_HALT;
        end else if (redirect_i) begin
          pc_d = redirect_pc_i;
        end else begin
          pc_d = pc_q + rv64_pkg::xlen_t'(4);
        end
      end
      default: begin
        // Halted until reset
        state_d = rv64_pkg::IFU_HALT;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q    <= `RV64_RESET_PC;
      state_q <= rv64_pkg::IFU_RUN;
    end else begin
      pc_q    <= pc_d;
      state_q <= state_d;
    end
  end

  assign pc_o     = pc_q;
  assign halted_o = (state_q == rv64_pkg::IFU_HALT);

  // Branch and jump targets from execute keep fetch word aligned
  a_pc_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pc_q[1:0] == 2'b00);

endmodule

/* hdl/rv64_pkg.sv */
`include "rv64_defines.svh"

package rv64_pkg;

  // Data word, instruction word and register index
  typedef logic [`RV64_XLEN-1:0]      xlen_t;
  typedef logic [`RV64_INST_W-1:0]    inst_t;
  typedef logic [`RV64_REG_IDX_W-1:0] reg_idx_t;

  // One-hot operation lines above the unit tag
  typedef logic [`RV64_EXU_INFO_W-1:0] exu_info_t;

  // Everything execute needs from decode
  typedef struct packed {
    logic      rd_wr_en;
    reg_idx_t  rd_idx;
    // ALU operands
    xlen_t     op1;
    xlen_t     op2;
    // Jump base and offset
    xlen_t     op1_jp;
    xlen_t     op2_jp;
    exu_info_t exu_info;
  } idu_to_exu_t;

  // Register write of the retiring instruction
  typedef struct packed {
    logic     en;
    reg_idx_t idx;
    xlen_t    data;
  } commit_t;

  // Fetch run/halt
  typedef enum logic {
    IFU_RUN  = 1'b0,
    IFU_HALT = 1'b1
  } ifu_state_t;

endpackage

/* hdl/rv64_regfile.sv */
`timescale 1ns/1ps
`include "rv64_defines.svh"

module rv64_regfile (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  rv64_pkg::reg_idx_t rs1_idx_i,
  input  rv64_pkg::reg_idx_t rs2_idx_i,
  input  logic               rs1_en_i,
  input  logic               rs2_en_i,
  output rv64_pkg::xlen_t    rs1_data_o,
  output rv64_pkg::xlen_t    rs2_data_o,
  input  rv64_pkg::commit_t  wb_i
);

  localparam int NUM_REGS = 1 << `RV64_REG_IDX_W;

  // x1..x31, x0 has no storage
  rv64_pkg::xlen_t regs_q [NUM_REGS-1:1];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wb_i.en && (wb_i.idx != '0)) begin
      regs_q[wb_i.idx] <= wb_i.data;
    end
  end

  // Disabled port or x0 reads zero
  assign rs1_data_o = (rs1_en_i && (rs1_idx_i != '0)) ? regs_q[rs1_idx_i] : '0;
  assign rs2_data_o = (rs2_en_i && (rs2_idx_i != '0)) ? regs_q[rs2_idx_i] : '0;

  // Decode drops the write enable for rd = x0
  a_no_x0_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_i.en |-> (wb_i.idx != '0));

endmodule

/* rv64_core.f */
+incdir+hdl
hdl/rv64_pkg.sv
hdl/rv64_ifu.sv
hdl/rv64_idu.sv
hdl/rv64_regfile.sv
hdl/rv64_exu.sv
hdl/rv64_core.sv
sim/tb_clk_gen.sv
sim/tb_rv64_core.sv

/* sim/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
  input  logic rst_req_i,
  output logic clk_o,
  output logic rst_n_o
);

  int unsigned rst_cnt;

  // 20 ns period
  initial begin
    clk_o   = 1'b0;
    rst_cnt = 10;
    forever #10 clk_o = ~clk_o;
  end

  // Reset held for 10 edges at start and after each request
  always @(posedge clk_o) begin
    if (rst_req_i) begin
      rst_cnt <= 10;
    end else if (rst_cnt != 0) begin
      rst_cnt <= rst_cnt - 1;
    end
  end

  assign rst_n_o = (rst_cnt == 0);

endmodule

/* sim/tb_rv64_core.sv */
`timescale 1ns/1ps
`include "rv64_defines.svh"

module tb_rv64_core;

  localparam int PROG_N   = 64;
  localparam int MAX_CYC  = 400;
  localparam int POST_CYC = 5;

  logic                  clk_i;
  logic                  rst_n_i;
  logic                  rst_req;
  rv64_pkg::inst_t       inst_i;
  rv64_pkg::xlen_t       pc_o;
  rv64_pkg::commit_t     commit_o;
  logic                  halted_o;
  logic                  invalid_o;

  // Program memory and the next program staged for the following reset
  rv64_pkg::inst_t prog [PROG_N];
  rv64_pkg::inst_t next_prog [PROG_N];

  // Model state
  rv64_pkg::xlen_t mregs [32];
  rv64_pkg::xlen_t mpc;
  logic            mhalted;

  int errors;
  int tests_run;
  int tests_failed;

  tb_clk_gen clk_gen (
    .rst_req_i (rst_req),
    .clk_o     (clk_i),
    .rst_n_o   (rst_n_i)
  );

  rv64_core dut (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .inst_i    (inst_i),
    .pc_o      (pc_o),
    .commit_o  (commit_o),
    .halted_o  (halted_o),
    .invalid_o (invalid_o)
  );

  // Word lookup that returns zero outside the program
  function automatic rv64_pkg::inst_t fetch_word(input rv64_pkg::xlen_t pc);
    rv64_pkg::xlen_t off;
    off = pc - `RV64_RESET_PC;
    if (pc < `RV64_RESET_PC || (off >> 2) >= PROG_N) begin
      return '0;
    end
    return prog[off[31:2]];
  endfunction

  always_comb begin
    inst_i = fetch_word(pc_o);
  end

  // Instruction encoders
  function automatic rv64_pkg::inst_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3,
                                            input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic rv64_pkg::inst_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [2:0] f3, input logic [4:0] rd,
                                            input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic rv64_pkg::inst_t enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic rv64_pkg::inst_t enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                            input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic rv64_pkg::inst_t enc_j(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  // Random R or I ALU op over x0..x7
  function automatic rv64_pkg::inst_t rand_alu();
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    rd  = 5'($urandom % 8);
    rs1 = 5'($urandom % 8);
    rs2 = 5'($urandom % 8);
    f3  = 3'($urandom % 8);
    imm = 12'($urandom);
    if ($urandom % 3 == 0) begin
      f7 = ((f3 == 3'd0 || f3 == 3'd5) && ($urandom % 2 == 1)) ? 7'h20 : 7'h00;
      return enc_r(f7, rs2, rs1, f3, rd);
    end
    if (f3 == 3'd1) begin
      imm = {6'h00, imm[5:0]};
    end else if (f3 == 3'd5) begin
      imm = {(($urandom % 2 == 1) ? 6'h10 : 6'h00), imm[5:0]};
    end
    return enc_i(imm, rs1, f3, rd, 7'b0010011);
  endfunction

  // Model of one instruction from the ISA rules
  function automatic void rv64_ref_step(input rv64_pkg::inst_t inst,
                                        input rv64_pkg::xlen_t pc,
                                        output rv64_pkg::commit_t c,
                                        output rv64_pkg::xlen_t npc,
                                        output logic stop, output logic bad);
    logic [6:0]      opc;
    logic [2:0]      f3;
    logic [6:0]      f7;
    logic [4:0]      rd;
    rv64_pkg::xlen_t a;
    rv64_pkg::xlen_t b;
    rv64_pkg::xlen_t imm_i;
    rv64_pkg::xlen_t imm_b;
    rv64_pkg::xlen_t imm_u;
    rv64_pkg::xlen_t imm_j;
    rv64_pkg::xlen_t res;
    logic            wr;
    logic            taken;
    opc   = inst[6:0];
    rd    = inst[11:7];
    f3    = inst[14:12];
    f7    = inst[31:25];
    a     = mregs[inst[19:15]];
    b     = mregs[inst[24:20]];
    imm_i = {{52{inst[31]}}, inst[31:20]};
    imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    imm_u = {{32{inst[31]}}, inst[31:12], 12'h000};
    imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    res   = '0;
    wr    = 1'b0;
    taken = 1'b0;
    stop  = 1'b0;
    bad   = 1'b0;
    npc   = pc + 64'd4;
    case (opc)
      7'b0110011, 7'b0010011: begin
        wr = 1'b1;
        // I form takes the immediate as second operand
        if (opc == 7'b0010011) begin
          b = imm_i;
        end
        case (f3)
          3'd0: begin
            if (opc == 7'b0110011 && f7 == 7'h20) res = a - b;
            else res = a + b;
            if (opc == 7'b0110011 && f7 != 7'h00 && f7 != 7'h20) bad = 1'b1;
          end
          3'd1: begin
            res = a << b[5:0];
            if (inst[31:26] != 6'h00 || (opc == 7'b0110011 && inst[25])) bad = 1'b1;
          end
          3'd2: res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
          3'd3: res = (a < b) ? 64'd1 : 64'd0;
          3'd4: res = a ^ b;
          3'd5: begin
            if (inst[30]) res = $signed(a) >>> b[5:0];
            else res = a >> b[5:0];
            if (inst[31] || inst[29:26] != 4'h0 || (opc == 7'b0110011 && inst[25])) begin
              bad = 1'b1;
            end
          end
          3'd6: res = a | b;
          default: res = a & b;
        endcase
        // Register forms need a zero funct7 apart from sub and sra
        if (opc == 7'b0110011 && f3 != 3'd0 && f3 != 3'd5 && f7 != 7'h00) bad = 1'b1;
      end
      7'b0110111: begin
        wr  = 1'b1;
        res = imm_u;
      end
      7'b0010111: begin
        wr  = 1'b1;
        res = pc + imm_u;
      end
      7'b1101111: begin
        wr  = 1'b1;
        res = pc + 64'd4;
        npc = pc + imm_j;
      end
      7'b1100111: begin
        wr  = 1'b1;
        res = pc + 64'd4;
        npc = (a + imm_i) & ~64'd1;
        if (f3 != 3'd0) bad = 1'b1;
      end
      7'b1100011: begin
        case (f3)
          3'd0: taken = (a == b);
          3'd1: taken = (a != b);
          3'd4: taken = ($signed(a) < $signed(b));
          3'd5: taken = ($signed(a) >= $signed(b));
          3'd6: taken = (a < b);
          3'd7: taken = (a >= b);
          default: bad = 1'b1;
        endcase
        if (taken) npc = pc + imm_b;
      end
      7'b1110011: begin
        if (inst == 32'h0010_0073) stop = 1'b1;
        else bad = 1'b1;
      end
      default: bad = 1'b1;
    endcase
    if (bad) stop = 1'b1;
    c.en   = wr && !bad && (rd != 5'd0);
    c.idx  = rd;
    c.data = res;
  endfunction

  task automatic check_commit(input rv64_pkg::commit_t got, input rv64_pkg::commit_t exp);
    if (got.en !== exp.en || (exp.en && (got.idx !== exp.idx || got.data !== exp.data))) begin
      errors++;
      $display("ERR %0t: commit en=%0b x%0d=%h, expected en=%0b x%0d=%h", $time,
               got.en, got.idx, got.data, exp.en, exp.idx, exp.data);
    end
  endtask

  task automatic check_pc(input rv64_pkg::xlen_t got, input rv64_pkg::xlen_t exp);
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: pc %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s is %0b, expected %0b", $time, what, got, exp);
    end
  endtask

  // Reset the core and swap in the staged program while reset is low
  task automatic reset_core();
    int n;
    n = 0;
    @(posedge clk_i);
    #1 rst_req = 1'b1;
    while (rst_n_i !== 1'b0) begin
      @(posedge clk_i);
      #1 n++;
      if (n > 20) begin
        $display("Reset never asserted");
        $display("Result: FAILED");
        $finish;
      end
    end
    for (int i = 0; i < PROG_N; i++) begin
      prog[i] = next_prog[i];
    end
    rst_req = 1'b0;
    n = 0;
    while (rst_n_i !== 1'b1) begin
      @(posedge clk_i);
      #2 n++;
      if (n > 20) begin
        $display("Reset never released");
        $display("Result: FAILED");
        $finish;
      end
    end
  endtask

  // Run the staged program to a halt with checks every cycle
  task automatic run_program(input string name);
    rv64_pkg::commit_t exp_c;
    rv64_pkg::xlen_t   npc;
    logic              stop;
    logic              bad;
    int                cyc;
    int                post;
    int                err0;
    err0 = errors;
    cyc  = 0;
    post = 0;
    reset_core();
    for (int r = 0; r < 32; r++) begin
      mregs[r] = '0;
    end
    mpc     = `RV64_RESET_PC;
    mhalted = 1'b0;
    while (post < POST_CYC) begin
      check_pc(pc_o, mpc);
      check_bit(halted_o, mhalted, "halted_o");
      rv64_ref_step(fetch_word(mpc), mpc, exp_c, npc, stop, bad);
      check_commit(commit_o, exp_c);
      check_bit(invalid_o, bad, "invalid_o");
      if (mhalted && halted_o) begin
        post++;
      end else if (!mhalted) begin
        if (exp_c.en) mregs[exp_c.idx] = exp_c.data;
        if (stop) mhalted = 1'b1;
        else mpc = npc;
      end
      @(posedge clk_i);
      #2 cyc++;
      if (cyc > MAX_CYC) begin
        $display("Test %s: the core never halted", name);
        $display("Result: FAILED");
        $finish;
      end
    end
    tests_run++;
    if (errors != err0) tests_failed++;
    $display("Test %s: %0d cycles, %0d errors", name, cyc, errors - err0);
  endtask

  // Fill with random ALU ops and put ebreak in the last slot
  task automatic build_alu(input int mode);
    for (int i = 0; i < PROG_N - 1; i++) begin
      next_prog[i] = rand_alu();
      // Upper immediates mixed in
      if (mode == 1 && $urandom % 2 == 1) begin
        next_prog[i] = enc_u(20'($urandom), 5'($urandom % 8),
                             ($urandom % 2 == 1) ? 7'b0110111 : 7'b0010111);
      end
      // rd forced to x0 half the time
      if (mode == 2 && $urandom % 2 == 1) begin
        next_prog[i][11:7] = 5'd0;
      end
    end
    next_prog[PROG_N-1] = 32'h0010_0073;
  endtask

  // Forward branches and jumps over random ALU ops
  task automatic build_bjp();
    int          i;
    int          tgt;
    logic [4:0]  rx;
    logic [2:0]  bf3 [6];
    // Slots that an earlier branch or jump lands on
    logic        hit [PROG_N];
    bf3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    for (int k = 0; k < PROG_N; k++) begin
      hit[k] = 1'b0;
    end
    build_alu(0);
    i = 0;
    while (i < PROG_N - 3) begin
      case ($urandom % 5)
        0: begin
          tgt = i + 1 + int'($urandom % (PROG_N - 1 - i));
          hit[tgt] = 1'b1;
          next_prog[i] = enc_b(13'((tgt - i) * 4), 5'($urandom % 8), 5'($urandom % 8),
                               bf3[$urandom % 6]);
          i++;
        end
        1: begin
          tgt = i + 1 + int'($urandom % (PROG_N - 1 - i));
          hit[tgt] = 1'b1;
          next_prog[i] = enc_j(21'((tgt - i) * 4), 5'($urandom % 8));
          i++;
        end
        2: begin
          if (hit[i + 1]) begin
            // A jalr entered without its auipc would jump from a random base
            i++;
          end else begin
            // auipc gives the base and odd offsets exercise the bit 0 clear
            rx  = 5'(1 + $urandom % 7);
            tgt = i + 2 + int'($urandom % (PROG_N - 2 - i));
            hit[tgt] = 1'b1;
            next_prog[i]     = enc_u(20'h0, rx, 7'b0010111);
            next_prog[i + 1] = enc_i(12'((tgt - i) * 4 + int'($urandom % 2)), rx, 3'd0,
                                     5'($urandom % 8), 7'b1100111);
            i += 2;
          end
        end
        default: i++;
      endcase
    end
  endtask

  initial begin
    void'($urandom(32'hcf3));
    rst_req      = 1'b0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    for (int i = 0; i < PROG_N; i++) begin
      prog[i]      = '0;
      next_prog[i] = '0;
    end

    // Sign and shift corner values up front
    build_alu(0);
    next_prog[0] = enc_i(12'hfff, 5'd0, 3'd0, 5'd1, 7'b0010011);
    next_prog[1] = enc_i(12'd63, 5'd1, 3'd1, 5'd2, 7'b0010011);
    next_prog[2] = enc_i(12'd63, 5'd0, 3'd0, 5'd4, 7'b0010011);
    next_prog[3] = enc_r(7'h20, 5'd4, 5'd2, 3'd5, 5'd3);
    next_prog[4] = enc_r(7'h00, 5'd0, 5'd1, 3'd2, 5'd5);
    next_prog[5] = enc_r(7'h00, 5'd1, 5'd0, 3'd3, 5'd6);
    next_prog[6] = enc_i(12'h43f, 5'd2, 3'd5, 5'd7, 7'b0010011);
    run_program("alu");

    build_alu(1);
    run_program("upper_imm");

    build_bjp();
    run_program("branch_jump");

    build_alu(2);
    run_program("x0_writes");

    build_alu(0);
    next_prog[20] = 32'h0010_0073;
    run_program("ebreak");

    build_alu(0);
    // ld x3, 0(x1)
    next_prog[10] = enc_i(12'h000, 5'd1, 3'd3, 5'd3, 7'b0000011);
    run_program("invalid_load");

    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
